/* cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ==================================================
// Cache geometry
// ==================================================
`define CACHE_WAYS            4
`define CACHE_SETS            16
`define CACHE_WORDS_PER_BLOCK 4
`define CACHE_WORD_W          32
`define CACHE_ADDR_W          32   // Word address

// ==================================================
// Derived field widths
// ==================================================
`define CACHE_OFF_W      $clog2(`CACHE_WORDS_PER_BLOCK)
`define CACHE_SET_W      $clog2(`CACHE_SETS)
`define CACHE_TAG_W      (`CACHE_ADDR_W - `CACHE_SET_W - `CACHE_OFF_W)
`define CACHE_BLK_ADDR_W (`CACHE_ADDR_W - `CACHE_OFF_W)   // Block number on memory bus
`define CACHE_WAY_W      $clog2(`CACHE_WAYS)
`define CACHE_TREE_W     (`CACHE_WAYS - 1)                 // Pseudo-LRU nodes per set

`endif

/* cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;
    typedef logic [`CACHE_SET_W-1:0]  set_idx_t;
    typedef logic [`CACHE_OFF_W-1:0]  offset_t;
    typedef logic [`CACHE_WAY_W-1:0]  way_t;

    // Heap order, bit 0 is the root, bits 1 and 2 its left and right children.
    // A node at 0 marks its left subtree as least recently used.
    typedef logic [`CACHE_TREE_W-1:0] plru_bits_t;

    typedef struct packed {
        tag_t     tag;
        set_idx_t idx;
        offset_t  off;
    } cache_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef logic [`CACHE_WORDS_PER_BLOCK-1:0][`CACHE_WORD_W-1:0] block_t;

    typedef struct packed {
        logic        valid;
        logic        we;      // 1 = write
        cache_addr_t addr;
        word_t       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                         stb;   // Cycle and strobe together
        logic                         we;
        logic [`CACHE_BLK_ADDR_W-1:0] addr;
        block_t                       wdata;
    } mem_req_t;

    typedef struct packed {
        logic cpu_write;   // Merge request word into hit way
        logic refill;      // Install memory block in victim
        logic clean;       // Victim written back
        logic touch;       // Access for replacement state
    } cache_cmd_t;

endpackage

`default_nettype wire

/* cache_set_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_set_ram import cache_pkg::*; #(
    parameter type entry_t = tag_entry_t
) (
    input  logic                   clk,
    input  logic                   rst,
    input  set_idx_t               set_idx,
    output entry_t                 rd [`CACHE_WAYS],
    input  logic [`CACHE_WAYS-1:0] we,   // One bit per way
    input  entry_t                 wr
);

    entry_t mem [`CACHE_SETS][`CACHE_WAYS];

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (we[w]) begin
                    mem[set_idx][w] <= wr;
                end
            end
        end
    end

    // All ways of the addressed set, no read latency
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            rd[w] = mem[set_idx][w];
        end
    end

endmodule

`default_nettype wire

/* cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_datapath import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_req_t               cpu_req,
    input  cache_cmd_t             cmd,
    input  way_t                   victim,
    input  block_t                 mem_rdata,
    output logic                   hit,
    output way_t                   hit_way,
    output logic [`CACHE_WAYS-1:0] valid_mask,
    output logic                   victim_dirty,
    output tag_t                   victim_tag,
    output block_t                 victim_block,
    output word_t                  rdata
);

    tag_entry_t             tag_rd [`CACHE_WAYS];
    block_t                 data_rd [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] match;
    way_t                   match_way;
    logic [`CACHE_WAYS-1:0] tag_we;
    logic [`CACHE_WAYS-1:0] data_we;
    tag_entry_t             tag_wr;
    block_t                 data_wr;
    block_t                 merged;

    cache_set_ram #(.entry_t(tag_entry_t)) u_tag_ram (
        .clk     (clk),
        .rst     (rst),
        .set_idx (cpu_req.addr.idx),
        .rd      (tag_rd),
        .we      (tag_we),
        .wr      (tag_wr)
    );

    cache_set_ram #(.entry_t(block_t)) u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .set_idx (cpu_req.addr.idx),
        .rd      (data_rd),
        .we      (data_we),
        .wr      (data_wr)
    );

    // ==================================================
    // Lookup
    // ==================================================
    always_comb begin
        match_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            valid_mask[w] = tag_rd[w].valid;
            match[w]      = tag_rd[w].valid && (tag_rd[w].tag == cpu_req.addr.tag);
            if (match[w]) begin
                match_way = way_t'(w);
            end
        end
    end

    assign hit          = |match;
    assign hit_way      = hit ? match_way : victim;   // Also the way touched on refill
    assign rdata        = data_rd[hit_way][cpu_req.addr.off];
    assign victim_dirty = tag_rd[victim].valid && tag_rd[victim].dirty;
    assign victim_tag   = tag_rd[victim].tag;
    assign victim_block = data_rd[victim];

    // Write word dropped into its slot
    always_comb begin
        merged                   = data_rd[hit_way];
        merged[cpu_req.addr.off] = cpu_req.wdata;
    end

    // ==================================================
    // Array writes from controller commands
    // ==================================================
    always_comb begin
        tag_we  = '0;
        data_we = '0;
        tag_wr  = tag_rd[victim];
        data_wr = mem_rdata;

        if (cmd.cpu_write) begin
            tag_we[hit_way]  = 1'b1;
            data_we[hit_way] = 1'b1;
            tag_wr.valid     = 1'b1;
            tag_wr.dirty     = 1'b1;
            tag_wr.tag       = cpu_req.addr.tag;
            data_wr          = merged;
        end else if (cmd.refill) begin
            tag_we[victim]  = 1'b1;
            data_we[victim] = 1'b1;
            tag_wr.valid    = 1'b1;
            tag_wr.dirty    = 1'b0;   // Fresh from memory
            tag_wr.tag      = cpu_req.addr.tag;
        end else if (cmd.clean) begin
            tag_we[victim] = 1'b1;
            tag_wr.dirty   = 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        cpu_req.valid |-> $onehot0(match))
        else $error("tag match in more than one way: %b", match);

    // Controller only merges a word into a resident block
    assert property (@(posedge clk) disable iff (rst)
        cmd.cpu_write |-> hit)
        else $error("cpu_write without a hit");

endmodule

`default_nettype wire

/* plru_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module plru_tracker import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  set_idx_t               set_idx,
    input  logic                   touch,
    input  way_t                   touch_way,
    input  logic [`CACHE_WAYS-1:0] valid_mask,
    output way_t                   victim
);

    plru_bits_t tree [`CACHE_SETS];
    plru_bits_t cur;

    assign cur = tree[set_idx];

    // Lowest invalid way first, else follow the tree to the LRU leaf
    always_comb begin
        victim = {cur[0], (cur[0] ? cur[2] : cur[1])};
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim = way_t'(w);
            end
        end
    end

    // ==================================================
    // Each node on the touched path points away
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set_idx][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[set_idx][2] <= ~touch_way[0];   // Right pair
            end else begin
                tree[set_idx][1] <= ~touch_way[0];   // Left pair
            end
        end
    end

    // A touched way holds a valid block once the access is done
    assert property (@(posedge clk) disable iff (rst)
        touch |=> set_idx != $past(set_idx) || valid_mask[$past(touch_way)])
        else $error("touched way is still invalid after the access");

endmodule

`default_nettype wire

/* cache_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm import cache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_req_t   cpu_req,
    input  logic       hit,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    input  block_t     victim_block,
    input  logic       mem_ack,
    output cache_cmd_t cmd,
    output mem_req_t   mem_req,
    output logic       done
);

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        REFILL,
        FINISH
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==================================================
    // Next state and outputs
    // ==================================================
    always_comb begin
        state_nxt = state;
        cmd       = '0;
        mem_req   = '0;
        done      = 1'b0;

        case (state)
            IDLE: begin
                if (cpu_req.valid) begin
                    state_nxt = COMPARE;
                end
            end

            COMPARE: begin
                if (hit) begin
                    done          = 1'b1;
                    cmd.touch     = 1'b1;
                    cmd.cpu_write = cpu_req.we;
                    state_nxt     = IDLE;
                end else if (victim_dirty) begin
                    state_nxt = WRITE_BACK;
                end else begin
                    state_nxt = REFILL;
                end
            end

            WRITE_BACK: begin
                // Victim block goes back to its own address
                mem_req.stb   = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = {victim_tag, cpu_req.addr.idx};
                mem_req.wdata = victim_block;
                if (mem_ack) begin
                    cmd.clean = 1'b1;
                    state_nxt = REFILL;
                end
            end

            REFILL: begin
                mem_req.stb  = 1'b1;
                mem_req.addr = {cpu_req.addr.tag, cpu_req.addr.idx};
                if (mem_ack) begin
                    cmd.refill = 1'b1;
                    cmd.touch  = 1'b1;
                    state_nxt  = FINISH;
                end
            end

            FINISH: begin
                // Requested block now hits in the filled way
                done          = 1'b1;
                cmd.cpu_write = cpu_req.we;
                state_nxt     = IDLE;
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ==================================================
    // Protocol checks
    // ==================================================
    // Memory request held unchanged until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        mem_req.stb && !mem_ack |=> mem_req.stb && $stable(mem_req))
        else $error("mem_req changed or dropped before mem_ack");

    // CPU keeps its request steady while a miss is in flight
    assert property (@(posedge clk) disable iff (rst)
        state != IDLE && !done |=> $stable(cpu_req))
        else $error("cpu_req changed before done");

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top import cache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output logic     done,
    output word_t    rdata,
    output mem_req_t mem_req,
    input  logic     mem_ack,
    input  block_t   mem_rdata
);

    cache_cmd_t             cmd;
    logic                   hit;
    way_t                   hit_way;   // Hit way, or victim on a miss
    way_t                   victim;
    logic [`CACHE_WAYS-1:0] valid_mask;
    logic                   victim_dirty;
    tag_t                   victim_tag;
    block_t                 victim_block;

    cache_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_block (victim_block),
        .mem_ack      (mem_ack),
        .cmd          (cmd),
        .mem_req      (mem_req),
        .done         (done)
    );

    cache_datapath u_dp (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cmd          (cmd),
        .victim       (victim),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_mask   (valid_mask),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_block (victim_block),
        .rdata        (rdata)
    );

    plru_tracker u_plru (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (cpu_req.addr.idx),
        .touch      (cmd.touch),
        .touch_way  (hit_way),
        .valid_mask (valid_mask),
        .victim     (victim)
    );

endmodule

`default_nettype wire

/* tb_cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache_checker import cache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    input  logic     done,
    input  word_t    rdata,
    input  mem_req_t mem_req,
    input  logic     mem_ack,
    output int       err_count,
    output int       test_count
);

    // ==================================================
    // Reference model of tags, tree bits and memory
    // ==================================================
    tag_entry_t  tags [`CACHE_SETS][`CACHE_WAYS];
    plru_bits_t  tree [`CACHE_SETS];
    word_t       shadow [logic [`CACHE_ADDR_W-1:0]];

    cpu_req_t    req;        // Request in flight
    logic        active = 1'b0;
    logic        exp_hit;
    int          exp_way;    // Hit way or predicted victim
    logic        exp_wb;
    int          cycles;
    int          writes;
    int          reads;
    int          test_errs;

    initial begin
        err_count  = 0;
        test_count = 0;
    end

    function automatic word_t shadow_word(input logic [`CACHE_ADDR_W-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a;   // Untouched memory holds its own address
    endfunction

    function automatic int pick_victim(input int s);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!tags[s][w].valid) begin
                return w;
            end
        end
        if (tree[s][0] == 1'b0) begin
            return tree[s][1] ? 1 : 0;
        end
        return tree[s][2] ? 3 : 2;
    endfunction

    // Path nodes point away from the used way
    task automatic mark_used(input int s, input int way);
        if (way < 2) begin
            tree[s][0] = 1'b1;
            tree[s][1] = (way == 0);
        end else begin
            tree[s][0] = 1'b0;
            tree[s][2] = (way == 2);
        end
    endtask

    task automatic flag_error(input string msg);
        $display("%s", msg);
        test_errs++;
        err_count++;
    endtask

    task automatic start_request();
        int s;
        req     = cpu_req;
        s       = req.addr.idx;
        exp_hit = 1'b0;
        exp_way = pick_victim(s);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (tags[s][w].valid && tags[s][w].tag == req.addr.tag) begin
                exp_hit = 1'b1;
                exp_way = w;
            end
        end
        exp_wb    = !exp_hit && tags[s][exp_way].valid && tags[s][exp_way].dirty;
        cycles    = 0;
        writes    = 0;
        reads     = 0;
        test_errs = 0;
        active    = 1'b1;
    endtask

    task automatic observe_exchange();
        logic [`CACHE_BLK_ADDR_W-1:0] blk;
        word_t                        exp_word;
        int                           s;
        s = req.addr.idx;
        if (mem_req.we) begin
            blk = {tags[s][exp_way].tag, req.addr.idx};
            if (!exp_wb || writes != 0 || reads != 0) begin
                flag_error($sformatf("unexpected memory write to block %h", mem_req.addr));
            end else if (mem_req.addr !== blk) begin
                flag_error($sformatf("error mem_req.addr expected %h got %h",
                                     blk, mem_req.addr));
            end else begin
                for (int w = 0; w < `CACHE_WORDS_PER_BLOCK; w++) begin
                    exp_word = shadow_word({blk, offset_t'(w)});
                    if (mem_req.wdata[w] !== exp_word) begin
                        flag_error($sformatf("error mem_req.wdata[%0d] expected %h got %h",
                                             w, exp_word, mem_req.wdata[w]));
                    end
                end
            end
            writes++;
        end else begin
            blk = {req.addr.tag, req.addr.idx};
            if (exp_hit || reads != 0) begin
                flag_error($sformatf("unexpected memory read of block %h", mem_req.addr));
            end else if (exp_wb && writes == 0) begin
                flag_error("refill read came before the write-back");
            end else if (mem_req.addr !== blk) begin
                flag_error($sformatf("error mem_req.addr expected %h got %h",
                                     blk, mem_req.addr));
            end
            reads++;
        end
    endtask

    task automatic finish_request();
        word_t exp_word;
        int    s;
        s = req.addr.idx;
        if (exp_hit && cycles != 2) begin
            flag_error($sformatf("hit took %0d cycles from accept to done", cycles - 1));
        end
        if (!exp_hit && reads != 1) begin
            flag_error("miss completed without exactly one refill read");
        end
        if (exp_wb && writes != 1) begin
            flag_error("dirty victim was not written back");
        end
        exp_word = shadow_word(req.addr);
        if (!req.we && rdata !== exp_word) begin
            flag_error($sformatf("error rdata expected %h got %h", exp_word, rdata));
        end

        // Model follows the access
        if (!exp_hit) begin
            tags[s][exp_way].valid = 1'b1;
            tags[s][exp_way].dirty = 1'b0;
            tags[s][exp_way].tag   = req.addr.tag;
        end
        if (req.we) begin
            shadow[req.addr]       = req.wdata;
            tags[s][exp_way].dirty = 1'b1;
        end
        mark_used(s, exp_way);

        test_count++;
        $display("test %0d: %s %h %s way %0d %s", test_count, req.we ? "write" : "read",
                 req.addr, exp_hit ? "hit" : "miss", exp_way,
                 test_errs == 0 ? "ok" : "mismatch");
        active = 1'b0;
    endtask

    // ==================================================
    // Monitor, sampled mid-cycle
    // ==================================================
    always @(negedge clk) begin
        if (rst) begin
            if (done !== 1'b0) begin
                flag_error($sformatf("error done expected 0 got %h", done));
            end
            if (mem_req.stb !== 1'b0) begin
                flag_error($sformatf("error mem_req.stb expected 0 got %h", mem_req.stb));
            end
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] = '0;
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tags[s][w] = '0;
                end
            end
            active = 1'b0;
        end else begin
            if (cpu_req.valid && !active) begin
                start_request();
            end
            if (active) begin
                cycles++;
                if (mem_req.stb && mem_ack) begin
                    observe_exchange();
                end
                if (done) begin
                    finish_request();
                end
            end else if (mem_req.stb || done) begin
                flag_error("memory strobe or done seen with no request pending");
            end
        end
    end

endmodule

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache import cache_pkg::*; ();

    typedef struct packed {
        logic                     we;
        logic [`CACHE_ADDR_W-1:0] addr;
        word_t                    wdata;
    } stim_t;

    localparam int NUM_TESTS = 24;

    // Set 3 sees tags 1 to 9, forcing clean and dirty evictions
    stim_t stim [NUM_TESTS] = '{
        {1'b0, 32'h0000_0005, 32'h0},
        {1'b0, 32'h0000_0005, 32'h0},          // Hit
        {1'b1, 32'h0000_0006, 32'hdead_beef},
        {1'b0, 32'h0000_0006, 32'h0},
        {1'b0, 32'h0000_0004, 32'h0},
        {1'b0, 32'h0000_0007, 32'h0},
        {1'b0, 32'h0000_004c, 32'h0},
        {1'b1, 32'h0000_008d, 32'h1111_1111},  // Write miss
        {1'b0, 32'h0000_00cc, 32'h0},
        {1'b0, 32'h0000_010c, 32'h0},          // Set 3 now full
        {1'b0, 32'h0000_004c, 32'h0},
        {1'b0, 32'h0000_014c, 32'h0},          // Clean eviction
        {1'b0, 32'h0000_00cc, 32'h0},          // Evicted, dirty victim
        {1'b0, 32'h0000_008d, 32'h0},
        {1'b1, 32'h0000_004f, 32'h3333_3333},
        {1'b0, 32'h0000_018c, 32'h0},
        {1'b0, 32'h0000_01cc, 32'h0},
        {1'b0, 32'h0000_020c, 32'h0},
        {1'b0, 32'h0000_024c, 32'h0},
        {1'b0, 32'h0000_004f, 32'h0},
        {1'b0, 32'h0000_004e, 32'h0},
        {1'b1, 32'h1234_5670, 32'ha5a5_a5a5},
        {1'b0, 32'h1234_5670, 32'h0},
        {1'b0, 32'h1234_5673, 32'h0}
    };

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    logic     done;
    word_t    rdata;
    mem_req_t mem_req;
    logic     mem_ack;
    block_t   mem_rdata;
    int       err_count;
    int       test_count;
    int       wb_count = 0;

    cache_top uut (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .done      (done),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_cache_checker chk (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .done       (done),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .err_count  (err_count),
        .test_count (test_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Memory model with random ack delay
    // ==================================================
    initial begin : memory_model
        word_t                    mem_words [logic [`CACHE_ADDR_W-1:0]];
        logic [`CACHE_ADDR_W-1:0] waddr;
        integer                   seed;
        int                       delay;
        seed      = 32'h209f1d84;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (mem_req.stb) begin
                delay = $random(seed) & 3;   // 0 to 3 wait cycles
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                for (int w = 0; w < `CACHE_WORDS_PER_BLOCK; w++) begin
                    waddr = {mem_req.addr, offset_t'(w)};
                    if (mem_req.we) begin
                        mem_words[waddr] = mem_req.wdata[w];
                    end else begin
                        mem_rdata[w] = mem_words.exists(waddr) ? mem_words[waddr] : waddr;
                    end
                end
                if (mem_req.we) begin
                    wb_count++;
                end
                mem_ack = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * 40) @(posedge clk);
        $display("timeout: only %0d of %0d requests completed", test_count, NUM_TESTS);
        $display("Testbench failed");
        $finish;
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin : stimulus
        cpu_req = '0;
        rst     = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            #1;
            cpu_req.valid = 1'b1;
            cpu_req.we    = stim[i].we;
            cpu_req.addr  = stim[i].addr;
            cpu_req.wdata = stim[i].wdata;
            @(negedge clk);
            while (!done) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            cpu_req.valid = 1'b0;   // One idle cycle between requests
        end

        repeat (2) @(posedge clk);
        $display("tests %0d of %0d, errors %0d, write-backs %0d",
                 test_count, NUM_TESTS, err_count, wb_count);
        if (err_count == 0 && test_count == NUM_TESTS) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cache_pkg.sv
cache_set_ram.sv
cache_datapath.sv
plru_tracker.sv
cache_ctrl_fsm.sv
cache_top.sv
tb_cache_checker.sv
tb_cache.sv
